// File: hdl/core_pkg.sv
// Core package for the in-order integer pipeline
// Widths, opcode and funct constants, ALU operations and the stage payloads
package core_pkg;

    // Datapath and register file sizes
    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    // Major opcodes of the supported formats
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 groups shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 variants of the R format
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // ALU operations, PASS_B serves LUI
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    // Decoded instruction held in the ID register
    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
        logic                  use_imm;
        logic                  rd_we;
    } id_item_t;

    // Register read result held in the RR/EXE register
    typedef struct packed {
        id_item_t        instr;
        logic [XLEN-1:0] op_a;
        logic [XLEN-1:0] op_b;
    } rr_item_t;

    // Execute result held in the EXE/WB register
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
        logic [XLEN-1:0]       result;
    } wb_item_t;

endpackage

// File: hdl/wb_if.sv
// Writeback bus
// Carries the held writeback result to the register file and to the
// execute stage forwarding path
`timescale 1ns/1ps

interface wb_if
    import core_pkg::*;
();
    // Held item writes a register (x0 already excluded)
    logic                  fwd_valid;
    // One cycle pulse when that item retires
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;

    // Writeback stage drives everything
    modport wb_mp (output fwd_valid, output wr_en, output rd, output data);
    // Register file write port
    modport rr_mp (input wr_en, input rd, input data);
    // Forwarding source for execute
    modport exe_mp (input fwd_valid, input rd, input data);

endinterface

// File: hdl/decode_stage.sv
// Decode stage
// Takes one instruction per four-phase req/ack exchange, decodes the
// supported RV32I subset and loads the ID register
`timescale 1ns/1ps

module decode_stage
    import core_pkg::*;
(
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            instr_req_i,
    input  logic [XLEN-1:0] instr_i,
    input  logic            stall_i,
    output logic            instr_ack_o,
    output id_item_t        id_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       accept;
    logic       ack_q;
    id_item_t   dec;
    id_item_t   id_q;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    ////////////////////////////////////////////////////////////////////////////
    // Instruction decode

    always_comb begin
        dec         = '0;
        dec.rd      = instr_i[11:7];
        dec.rs1     = instr_i[19:15];
        dec.rs2     = instr_i[24:20];
        // Sign extended I immediate by default
        dec.imm     = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
        dec.alu_op  = ALU_ADD;
        case (opcode)
            OPC_LUI: begin
                dec.valid   = 1'b1;
                dec.alu_op  = ALU_PASS_B;
                dec.use_imm = 1'b1;
                // U immediate, low 12 bits zero
                dec.imm     = {instr_i[31:12], 12'b0};
            end
            OPC_OP_IMM: begin
                dec.valid   = 1'b1;
                dec.use_imm = 1'b1;
                case (funct3)
                    F3_ADD_SUB: dec.alu_op = ALU_ADD;
                    F3_XOR:     dec.alu_op = ALU_XOR;
                    F3_OR:      dec.alu_op = ALU_OR;
                    F3_AND:     dec.alu_op = ALU_AND;
                    // Immediate shifts and SLTI are not supported
                    default:    dec.valid  = 1'b0;
                endcase
            end
            OPC_OP: begin
                dec.valid = 1'b1;
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD_SUB: dec.alu_op = ALU_ADD;
                        F3_SLL:     dec.alu_op = ALU_SLL;
                        F3_SLT:     dec.alu_op = ALU_SLT;
                        F3_XOR:     dec.alu_op = ALU_XOR;
                        F3_SRL_SRA: dec.alu_op = ALU_SRL;
                        F3_OR:      dec.alu_op = ALU_OR;
                        F3_AND:     dec.alu_op = ALU_AND;
                        default:    dec.valid  = 1'b0;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    case (funct3)
                        F3_ADD_SUB: dec.alu_op = ALU_SUB;
                        F3_SRL_SRA: dec.alu_op = ALU_SRA;
                        default:    dec.valid  = 1'b0;
                    endcase
                end else begin
                    dec.valid = 1'b0;
                end
            end
            default: dec.valid = 1'b0;
        endcase
        // No register write for x0
        dec.rd_we = dec.valid && (dec.rd != '0);
        // Unsupported encodings leave as clean bubbles
        if (!dec.valid) begin
            dec = '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Input handshake and ID register

    // Ack rises only when the pipeline can take the item
    assign accept = instr_req_i && !ack_q && !stall_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_q <= 1'b0;
        end else if (accept) begin
            ack_q <= 1'b1;
        end else if (!instr_req_i) begin
            // Source withdrew its request, close the exchange
            ack_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            id_q <= '0;
        end else if (!stall_i) begin
            // Bubble when nothing is accepted this cycle
            id_q <= accept ? dec : '0;
        end
    end

    assign instr_ack_o = ack_q;
    assign id_o        = id_q;

endmodule

// File: hdl/regread_stage.sv
// Register read stage
// 32 entry register file with write-first reads, operand B selection
// and the RR/EXE register
`timescale 1ns/1ps

module regread_stage
    import core_pkg::*;
(
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     stall_i,
    input  id_item_t id_i,
    wb_if.rr_mp      wb,
    output rr_item_t rr_o
);

    logic [XLEN-1:0] regs_q [NUM_REGS];
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    rr_item_t        rr_d;
    rr_item_t        rr_q;

    ////////////////////////////////////////////////////////////////////////////
    // Register file

    // Write port fed by the retire pulse of writeback
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb.wr_en) begin
            regs_q[wb.rd] <= wb.data;
        end
    end

    // Write-first read, a value retiring this cycle is seen at once
    assign rs1_data = (wb.wr_en && (wb.rd == id_i.rs1)) ? wb.data : regs_q[id_i.rs1];
    assign rs2_data = (wb.wr_en && (wb.rd == id_i.rs2)) ? wb.data : regs_q[id_i.rs2];

    ////////////////////////////////////////////////////////////////////////////
    // Operand selection and RR/EXE register

    always_comb begin
        rr_d.instr = id_i;
        rr_d.op_a  = rs1_data;
        // Immediate replaces rs2 for I and U formats
        rr_d.op_b  = id_i.use_imm ? id_i.imm : rs2_data;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rr_q <= '0;
        end else if (!stall_i) begin
            rr_q <= rr_d;
        end
    end

    assign rr_o = rr_q;

endmodule

// File: hdl/execute_stage.sv
// Execute stage
// Forwards the writeback result into the source operands, evaluates
// the ALU and loads the EXE/WB register
`timescale 1ns/1ps

module execute_stage
    import core_pkg::*;
(
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     stall_i,
    input  rr_item_t rr_i,
    wb_if.exe_mp     wb,
    output wb_item_t wb_item_o
);

    logic                fwd_a;
    logic                fwd_b;
    logic [XLEN-1:0]     op_a;
    logic [XLEN-1:0]     op_b;
    logic [SHAMT_W-1:0]  shamt;
    logic [XLEN-1:0]     result;
    wb_item_t            wb_d;
    wb_item_t            wb_q;

    ////////////////////////////////////////////////////////////////////////////
    // WB to EXE forwarding

    // fwd_valid already excludes x0
    assign fwd_a = wb.fwd_valid && (wb.rd == rr_i.instr.rs1);
    // Immediate operand is never overridden
    assign fwd_b = wb.fwd_valid && !rr_i.instr.use_imm && (wb.rd == rr_i.instr.rs2);

    assign op_a  = fwd_a ? wb.data : rr_i.op_a;
    assign op_b  = fwd_b ? wb.data : rr_i.op_b;
    // Shift amount from the low bits of operand B
    assign shamt = op_b[SHAMT_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // ALU

    always_comb begin
        case (rr_i.instr.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            // Signed compare, result is 0 or 1
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            ALU_SLL:    result = op_a << shamt;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // EXE/WB register

    always_comb begin
        wb_d.valid  = rr_i.instr.valid;
        wb_d.rd     = rr_i.instr.rd;
        wb_d.rd_we  = rr_i.instr.rd_we;
        wb_d.result = result;
    end

    // Held under stall so commit data stays stable
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_q <= '0;
        end else if (!stall_i) begin
            wb_q <= wb_d;
        end
    end

    assign wb_item_o = wb_q;

endmodule

// File: hdl/writeback_stage.sv
// Writeback stage
// Runs the four-phase commit handshake for each valid item, issues the
// register write pulse and computes the global stall
`timescale 1ns/1ps

module writeback_stage
    import core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  wb_item_t              wb_item_i,
    input  logic                  commit_ack_i,
    output logic                  commit_req_o,
    output logic [REG_ADDR_W-1:0] commit_rd_o,
    output logic [XLEN-1:0]       commit_data_o,
    output logic                  stall_o,
    wb_if.wb_mp                   wb
);

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_REQ,
        WB_WAIT
    } wb_state_e;

    wb_state_e state_q;
    wb_state_e state_d;
    logic      retire;

    ////////////////////////////////////////////////////////////////////////////
    // Commit FSM

    always_comb begin
        state_d = state_q;
        retire  = 1'b0;
        case (state_q)
            // New valid item raises the request next cycle
            WB_IDLE: if (wb_item_i.valid) state_d = WB_REQ;
            // Sink took it, drop the request
            WB_REQ:  if (commit_ack_i) state_d = WB_WAIT;
            WB_WAIT: begin
                // Ack low again, item leaves the pipeline
                if (!commit_ack_i) begin
                    retire  = 1'b1;
                    state_d = WB_IDLE;
                end
            end
            default: state_d = WB_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= WB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign commit_req_o  = (state_q == WB_REQ);
    assign commit_rd_o   = wb_item_i.rd;
    assign commit_data_o = wb_item_i.result;

    // Whole pipeline freezes until the held item retires
    assign stall_o = wb_item_i.valid && !retire;

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding and register write

    assign wb.fwd_valid = wb_item_i.valid && wb_item_i.rd_we;
    assign wb.wr_en     = retire && wb_item_i.rd_we;
    assign wb.rd        = wb_item_i.rd;
    assign wb.data      = wb_item_i.result;

endmodule

// File: hdl/rv_pipe_top.sv
// Top level of the integer pipeline
// Decode, register read, execute and writeback in series with a shared
// writeback bus, four-phase instruction input and commit output
`timescale 1ns/1ps

module rv_pipe_top
    import core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    // Instruction input
    input  logic                  instr_req_i,
    input  logic [XLEN-1:0]       instr_i,
    output logic                  instr_ack_o,
    // Commit output
    output logic                  commit_req_o,
    output logic [REG_ADDR_W-1:0] commit_rd_o,
    output logic [XLEN-1:0]       commit_data_o,
    input  logic                  commit_ack_i
);

    id_item_t id_item;
    rr_item_t rr_item;
    wb_item_t wb_item;
    logic     stall;

    // Writeback result to register file and forwarding mux
    wb_if wb_bus ();

    decode_stage u_decode (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .instr_req_i (instr_req_i),
        .instr_i     (instr_i),
        .stall_i     (stall),
        .instr_ack_o (instr_ack_o),
        .id_o        (id_item)
    );

    regread_stage u_regread (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .stall_i (stall),
        .id_i    (id_item),
        .wb      (wb_bus),
        .rr_o    (rr_item)
    );

    execute_stage u_execute (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .stall_i   (stall),
        .rr_i      (rr_item),
        .wb        (wb_bus),
        .wb_item_o (wb_item)
    );

    // Source of the global stall
    writeback_stage u_writeback (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .wb_item_i     (wb_item),
        .commit_ack_i  (commit_ack_i),
        .commit_req_o  (commit_req_o),
        .commit_rd_o   (commit_rd_o),
        .commit_data_o (commit_data_o),
        .stall_o       (stall),
        .wb            (wb_bus)
    );

endmodule

// File: verification/rv_pipe_asserts.sv
// Handshake and register file checks for the integer pipeline
// Bound into the top level
`timescale 1ns/1ps

module rv_pipe_asserts
    import core_pkg::*;
(
    input logic                  clk_i,
    input logic                  rstn_i,
    input logic                  instr_req_i,
    input logic                  instr_ack_i,
    input logic                  commit_req_i,
    input logic                  commit_ack_i,
    input logic [REG_ADDR_W-1:0] commit_rd_i,
    input logic [XLEN-1:0]       commit_data_i,
    input logic [XLEN-1:0]       x0_value_i
);

    ////////////////////////////////////////////////////////////////////////////
    // Instruction input handshake

    // Source holds its request until acked
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $fell(instr_req_i) |-> instr_ack_i)
        else $error("instr_req_i dropped before instr_ack_o");
    a_ack_rise: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(instr_ack_i) |-> $past(instr_req_i))
        else $error("instr_ack_o rose without a request");
    // Ack follows the request down
    a_ack_fall: assert property (@(posedge clk_i) disable iff (!rstn_i)
        instr_ack_i && !instr_req_i |=> !instr_ack_i)
        else $error("instr_ack_o stayed high after the request fell");

    ////////////////////////////////////////////////////////////////////////////
    // Commit handshake and x0

    a_commit_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        commit_req_i && !commit_ack_i |=> commit_req_i)
        else $error("commit_req_o dropped before commit_ack_i");
    a_commit_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        commit_req_i |=> $stable(commit_rd_i) && $stable(commit_data_i))
        else $error("commit rd or data changed during a request");
    a_commit_ack: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(commit_ack_i) |-> commit_req_i)
        else $error("commit_ack_i rose without a request");
    a_x0_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        x0_value_i == '0)
        else $error("register x0 holds a nonzero value");

endmodule

bind rv_pipe_top rv_pipe_asserts u_asserts (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_req_i   (instr_req_i),
    .instr_ack_i   (instr_ack_o),
    .commit_req_i  (commit_req_o),
    .commit_ack_i  (commit_ack_i),
    .commit_rd_i   (commit_rd_o),
    .commit_data_i (commit_data_o),
    .x0_value_i    (u_regread.regs_q[0])
);

// File: verification/rv_pipe_tb.sv
// Testbench for the in-order integer pipeline
// LFSR driven instruction stream, register model and in-order commit compare
`timescale 1ns/1ps

module rv_pipe_tb
    import core_pkg::*;
();

    localparam logic [31:0] SEED = 32'h3524_b4f6;
    // Instructions sent per test
    localparam int N_RESET  = 32;
    localparam int N_RANDOM = 40;
    localparam int N_CHAIN  = 27;
    localparam int N_SLOW   = 30;
    localparam int N_ODD    = 6;
    localparam int TIMEOUT_CYCLES = (N_RESET + N_RANDOM + N_CHAIN + N_SLOW + N_ODD) * 12 + 200;

    logic                  clk_i = 1'b0;
    logic                  rstn_i;
    logic                  instr_req_i;
    logic [XLEN-1:0]       instr_i;
    logic                  instr_ack_o;
    logic                  commit_req_o;
    logic [REG_ADDR_W-1:0] commit_rd_o;
    logic [XLEN-1:0]       commit_data_o;
    logic                  commit_ack_i;

    logic [31:0] lfsr_q = SEED;
    logic [31:0] model_regs [32];
    // Expected commits, {rd, value}
    logic [36:0] exp_q [$];
    logic        slow_sink;
    logic        req_prev = 1'b0;
    string       test_name;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          checks_at_start;
    int          errors_at_start;

    rv_pipe_top DUT (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_req_i   (instr_req_i),
        .instr_i       (instr_i),
        .instr_ack_o   (instr_ack_o),
        .commit_req_o  (commit_req_o),
        .commit_rd_o   (commit_rd_o),
        .commit_data_o (commit_data_o),
        .commit_ack_i  (commit_ack_i)
    );

    always #10 clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers and instruction encoders

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            bits   = {bits[30:0], lfsr_q[0]};
        end
        return bits;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // One random instruction of the supported subset
    function automatic logic [31:0] rand_instr();
        logic [31:0] r;
        logic [31:0] ins;
        r = rand_bits(31);
        case (int'(r[30:27]) % 14)
            0:       ins = {r[19:0], r[26:22], 7'b0110111};
            1:       ins = enc_i(r[11:0], 3'b000, r[26:22], r[21:17]);
            2:       ins = enc_i(r[11:0], 3'b100, r[26:22], r[21:17]);
            3:       ins = enc_i(r[11:0], 3'b110, r[26:22], r[21:17]);
            4:       ins = enc_i(r[11:0], 3'b111, r[26:22], r[21:17]);
            5:       ins = enc_r(7'h00, 3'b000, r[26:22], r[21:17], r[16:12]);
            6:       ins = enc_r(7'h20, 3'b000, r[26:22], r[21:17], r[16:12]);
            7:       ins = enc_r(7'h00, 3'b001, r[26:22], r[21:17], r[16:12]);
            8:       ins = enc_r(7'h00, 3'b010, r[26:22], r[21:17], r[16:12]);
            9:       ins = enc_r(7'h00, 3'b100, r[26:22], r[21:17], r[16:12]);
            10:      ins = enc_r(7'h00, 3'b101, r[26:22], r[21:17], r[16:12]);
            11:      ins = enc_r(7'h20, 3'b101, r[26:22], r[21:17], r[16:12]);
            12:      ins = enc_r(7'h00, 3'b110, r[26:22], r[21:17], r[16:12]);
            default: ins = enc_r(7'h00, 3'b111, r[26:22], r[21:17], r[16:12]);
        endcase
        return ins;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    // Returns 0 for encodings that must not commit
    function automatic bit model_exec(input logic [31:0] ins, output logic [4:0] rd,
                                      output logic [31:0] val);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        bit          ok;
        rd  = ins[11:7];
        a   = model_regs[ins[19:15]];
        b   = model_regs[ins[24:20]];
        imm = {{20{ins[31]}}, ins[31:20]};
        ok  = 1'b1;
        val = '0;
        case (ins[6:0])
            7'b0110111: val = {ins[31:12], 12'b0};
            7'b0010011: begin
                case (ins[14:12])
                    3'b000:  val = a + imm;
                    3'b100:  val = a ^ imm;
                    3'b110:  val = a | imm;
                    3'b111:  val = a & imm;
                    default: ok = 1'b0;
                endcase
            end
            7'b0110011: begin
                case ({ins[31:25], ins[14:12]})
                    {7'h00, 3'b000}: val = a + b;
                    {7'h20, 3'b000}: val = a - b;
                    {7'h00, 3'b001}: val = a << b[4:0];
                    {7'h00, 3'b010}: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    {7'h00, 3'b100}: val = a ^ b;
                    {7'h00, 3'b101}: val = a >> b[4:0];
                    {7'h20, 3'b101}: val = $unsigned($signed(a) >>> b[4:0]);
                    {7'h00, 3'b110}: val = a | b;
                    {7'h00, 3'b111}: val = a & b;
                    default:         ok = 1'b0;
                endcase
            end
            default: ok = 1'b0;
        endcase
        // x0 stays zero, the commit still shows the computed value
        if (ok && rd != 5'd0) begin
            model_regs[rd] = val;
        end
        return ok;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Input driver, commit sink and helpers

    task automatic send_instr(input logic [31:0] ins);
        logic [4:0]  rd;
        logic [31:0] val;
        if (model_exec(ins, rd, val)) begin
            exp_q.push_back({rd, val});
        end
        repeat (rand_bits(2)) @(negedge clk_i);
        instr_i     = ins;
        instr_req_i = 1'b1;
        @(negedge clk_i);
        while (!instr_ack_o) @(negedge clk_i);
        instr_req_i = 1'b0;
        @(negedge clk_i);
        while (instr_ack_o) @(negedge clk_i);
    endtask

    task automatic sink_commit();
        if (slow_sink) repeat (rand_bits(2)) @(negedge clk_i);
        commit_ack_i = 1'b1;
        @(negedge clk_i);
        while (commit_req_o) @(negedge clk_i);
        if (slow_sink) repeat (rand_bits(2)) @(negedge clk_i);
        commit_ack_i = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    // Wait until every expected commit has been seen and the sink is idle
    task automatic end_test();
        while (exp_q.size() != 0 || commit_req_o || commit_ack_i) @(negedge clk_i);
        repeat (2) @(negedge clk_i);
        $display("%-16s done: %0d commits checked, %0d errors", test_name,
                 checks - checks_at_start, errors - errors_at_start);
    endtask

    initial begin
        commit_ack_i = 1'b0;
        forever begin
            @(negedge clk_i);
            if (commit_req_o) sink_commit();
        end
    end

    // Compare on each rise of the commit request
    always @(negedge clk_i) begin
        logic [36:0] exp_item;
        if (commit_req_o && !req_prev) begin
            if (exp_q.size() == 0) begin
                $display("Commit of rd %0d in %s with no instruction outstanding",
                         commit_rd_o, test_name);
                errors++;
            end else begin
                exp_item = exp_q.pop_front();
                checks++;
                assert (commit_rd_o == exp_item[36:32] && commit_data_o == exp_item[31:0])
                else begin
                    $display("CHECK FAILED %s: expected rd %0d data %h, actual rd %0d data %h",
                             test_name, exp_item[36:32], exp_item[31:0], commit_rd_o,
                             commit_data_o);
                    errors++;
                end
            end
        end
        req_prev = commit_req_o;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        logic [31:0] r;
        rstn_i      = 1'b0;
        instr_req_i = 1'b0;
        instr_i     = '0;
        slow_sink   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(negedge clk_i);
        rstn_i = 1'b1;

        start_test("reset");
        assert (!instr_ack_o) else begin
            $display("CHECK FAILED reset: expected instr_ack_o 0, actual %0d", instr_ack_o);
            errors++;
        end
        assert (!commit_req_o) else begin
            $display("CHECK FAILED reset: expected commit_req_o 0, actual %0d", commit_req_o);
            errors++;
        end
        // ADD xN, xN, x0 reads every register
        for (int n = 0; n < N_RESET; n++) begin
            send_instr(enc_r(7'h00, 3'b000, 5'(n), 5'(n), 5'd0));
        end
        end_test();

        start_test("random");
        for (int n = 0; n < N_RANDOM; n++) send_instr(rand_instr());
        end_test();

        // Producer, d-1 fillers, then the consumer of x5
        start_test("chains");
        for (int d = 1; d <= 3; d++) begin
            for (int k = 0; k < 3; k++) begin
                r = rand_bits(12);
                send_instr(enc_i(r[11:0], 3'b000, 5'd5, 5'd0));
                for (int f = 1; f < d; f++) send_instr(enc_i(12'd1, 3'b000, 5'd7, 5'd7));
                send_instr(enc_r(7'h00, 3'b000, 5'd6, 5'd5, 5'd5));
            end
        end
        end_test();

        start_test("slow sink");
        slow_sink = 1'b1;
        for (int n = 0; n < N_SLOW; n++) send_instr(rand_instr());
        end_test();
        slow_sink = 1'b0;

        start_test("odd encodings");
        // SLTI, MUL and BEQ are outside the subset
        send_instr(enc_i(12'd5, 3'b010, 5'd9, 5'd1));
        send_instr(enc_r(7'h01, 3'b000, 5'd9, 5'd1, 5'd2));
        send_instr(32'h0000_0063);
        send_instr(enc_i(12'h123, 3'b000, 5'd9, 5'd0));
        // Write to x0, then read it back
        send_instr(enc_i(12'h7ff, 3'b000, 5'd0, 5'd0));
        send_instr(enc_r(7'h00, 3'b000, 5'd8, 5'd0, 5'd0));
        end_test();

        $display("Summary: 5 tests, %0d commits checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: rv_pipe.f
hdl/core_pkg.sv
hdl/wb_if.sv
hdl/decode_stage.sv
hdl/regread_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/rv_pipe_top.sv
verification/rv_pipe_asserts.sv
verification/rv_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f rv_pipe.f --top-module rv_pipe_tb -o rv_pipe_sim \
    && ./obj_dir/rv_pipe_sim | tee sim.log \
    || { echo "Build or run failed"; exit 1; }

grep -q "^NO ERRORS$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
